//--- rtl/pcs_rx_defs.svh
`ifndef PCS_RX_DEFS_SVH
`define PCS_RX_DEFS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////
`define PCS_CODED_W     66  // sync header + payload
`define PCS_DATA_W      64  // xgmii data, 8 lanes
`define PCS_CTRL_W      8   // one control bit per lane
`define PCS_SCR_W       58  // x^58 + x^39 + 1
`define PCS_RX_LATENCY  3   // descrambler, decoder, fsm

////////////////////////////////////////
// xgmii characters
////////////////////////////////////////
`define XGMII_IDLE   8'h07
`define XGMII_START  8'hFB
`define XGMII_TERM   8'hFD
`define XGMII_ERROR  8'hFE
`define XGMII_SEQ    8'h9C  // sequence ordered set, O code 0
`define XGMII_SIG    8'h5C  // signal ordered set, O code F

// 7-bit control codes inside a 64b/66b block
`define PCS_IDLE   7'h00
`define PCS_ERROR  7'h1E

////////////////////////////////////////
// block type field
////////////////////////////////////////
`define BT_CTRL   8'h1E
`define BT_START  8'h78
`define BT_ORDER  8'h4B
`define BT_T0     8'h87
`define BT_T1     8'h99
`define BT_T2     8'hAA
`define BT_T3     8'hB4
`define BT_T4     8'hCC
`define BT_T5     8'hD2
`define BT_T6     8'hE1
`define BT_T7     8'hFF

`endif

//--- rtl/pcs_rx_pkg.sv
package pcs_rx_pkg;

  ////////////////////////////////////////
  // block class, decoder to fsm
  ////////////////////////////////////////
  typedef enum logic [2:0]
  {
    BLK_E,  // bad header, type, O code or character
    BLK_C,  // control or ordered set
    BLK_S,  // start
    BLK_D,  // data
    BLK_T   // any of T0..T7
  } block_class_t;

  ////////////////////////////////////////
  // receive fsm states
  ////////////////////////////////////////
  typedef enum logic [1:0]
  {
    RX_INIT,  // local fault until link sees C or S
    RX_C,     // between frames
    RX_D,     // inside a frame
    RX_E      // error, waiting for a legal block
  } rx_state_t;

endpackage

//--- rtl/rx_descrambler.sv
`timescale 1ns/10ps
`include "pcs_rx_defs.svh"

module rx_descrambler
(
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_valid,
  input  logic [`PCS_CODED_W-1:0] i_block,
  output logic                    o_valid,
  output logic [`PCS_CODED_W-1:0] o_block
);

  localparam int TAP_39 = 38;              // x^39 term
  localparam int TAP_58 = `PCS_SCR_W - 1;  // x^58 term

  logic [`PCS_SCR_W-1:0]  scr_state;   // last 58 received bits
  logic [`PCS_SCR_W-1:0]  scr_next;
  logic [`PCS_DATA_W-1:0] plain;

  // self-synchronising: the scrambled bit, not the result, feeds the state
  always_comb
  begin
    scr_next = scr_state;
    for (int i = 0; i < `PCS_DATA_W; i++)  // bit 0 goes first on the line
    begin
      plain[i] = i_block[i] ^ scr_next[TAP_39] ^ scr_next[TAP_58];
      scr_next = {scr_next[`PCS_SCR_W-2:0], i_block[i]};
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
    begin
      scr_state <= '0;
      o_valid   <= 1'b0;
    end
    else
    begin
      o_valid <= i_valid;
      if (i_valid)
        scr_state <= scr_next;  // holds across gaps
    end
  end

  // header is never scrambled
  always_ff @(posedge i_clock)
  begin
    if (i_valid)
      o_block <= {i_block[`PCS_CODED_W-1:`PCS_DATA_W], plain};
  end

endmodule

//--- rtl/decoder_comparator.sv
`timescale 1ns/10ps
`include "pcs_rx_defs.svh"

module decoder_comparator
  import pcs_rx_pkg::*;
(
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_valid,
  input  logic [`PCS_CODED_W-1:0] i_rx_coded,
  output logic                    o_valid,
  output logic [`PCS_DATA_W-1:0]  o_rx_data,
  output logic [`PCS_CTRL_W-1:0]  o_rx_ctrl,
  output block_class_t            o_block_class
);

  localparam logic [1:0] SH_DATA   = 2'b01;
  localparam logic [1:0] SH_CTRL   = 2'b10;
  localparam int         NUM_LANES = `PCS_CTRL_W;
  localparam int         CHAR0_MSB = `PCS_DATA_W - 9;  // slot 0 sits right under the type byte

  logic [`PCS_CODED_W-1:0] rx_coded;   // latched block
  logic                    rx_valid;
  logic [1:0]              sync_hdr;
  logic [`PCS_DATA_W-1:0]  payload;
  logic [7:0]              block_type;
  logic [3:0]              o_code;
  logic [`PCS_DATA_W-1:0]  term_bytes;  // payload bytes 1..7 moved up one lane
  logic [7:0]              char_byte [NUM_LANES];
  logic [NUM_LANES-1:0]    char_ok;     // slot j holds 00 or 1E
  logic                    term_hit;
  logic [2:0]              term_k;      // lane of the /T/
  logic                    fill_ok;
  logic [`PCS_DATA_W-1:0]  dec_data;
  logic [`PCS_CTRL_W-1:0]  dec_ctrl;
  block_class_t            dec_class;

  // 7-bit code to xgmii char, msb flags a legal code
  function automatic logic [8:0] map_char(input logic [6:0] pcs_char);
    case (pcs_char)
      `PCS_IDLE:
        map_char = {1'b1, `XGMII_IDLE};
      `PCS_ERROR:
        map_char = {1'b1, `XGMII_ERROR};
      default:
        map_char = {1'b0, `XGMII_ERROR};  // anything else is an error block
    endcase
  endfunction

  ////////////////////////////////////////
  // input latch
  ////////////////////////////////////////
  always_ff @(posedge i_clock)
  begin
    if (i_reset)
      rx_valid <= 1'b0;
    else
      rx_valid <= i_valid;
  end

  always_ff @(posedge i_clock)
  begin
    if (i_valid)
      rx_coded <= i_rx_coded;
  end

  ////////////////////////////////////////
  // field split
  ////////////////////////////////////////
  assign sync_hdr   = rx_coded[`PCS_CODED_W-1 -: 2];   // 65:64
  assign payload    = rx_coded[`PCS_DATA_W-1:0];
  assign block_type = payload[`PCS_DATA_W-1 -: 8];     // top byte
  assign o_code     = payload[31:28];                  // ordered set O code
  assign term_bytes = {payload[`PCS_DATA_W-9:0], 8'h00};

  // every slot is mapped, each block type picks the ones it needs
  always_comb
  begin
    for (int j = 0; j < NUM_LANES; j++)
    begin
      {char_ok[j], char_byte[j]} = map_char(payload[CHAR0_MSB-7*j -: 7]);
    end
  end

  // terminate type to lane of /T/
  always_comb
  begin
    term_hit = 1'b1;
    term_k   = 3'd0;
    case (block_type)
      `BT_T0: term_k = 3'd0;
      `BT_T1: term_k = 3'd1;
      `BT_T2: term_k = 3'd2;
      `BT_T3: term_k = 3'd3;
      `BT_T4: term_k = 3'd4;
      `BT_T5: term_k = 3'd5;
      `BT_T6: term_k = 3'd6;
      `BT_T7: term_k = 3'd7;
      default: term_hit = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // decode and classify
  ////////////////////////////////////////
  always_comb
  begin
    dec_data  = {NUM_LANES{`XGMII_ERROR}};  // error block unless a check passes
    dec_ctrl  = '1;
    dec_class = BLK_E;
    fill_ok   = 1'b1;
    if (sync_hdr == SH_DATA)
    begin
      dec_data  = payload;
      dec_ctrl  = '0;
      dec_class = BLK_D;
    end
    else if (sync_hdr == SH_CTRL)
    begin
      if (block_type == `BT_CTRL)
      begin
        for (int j = 0; j < NUM_LANES; j++)
        begin
          dec_data[`PCS_DATA_W-1-8*j -: 8] = char_byte[j];
        end
        if (&char_ok)
          dec_class = BLK_C;
      end
      else if (block_type == `BT_START)
      begin
        dec_data  = {`XGMII_START, payload[`PCS_DATA_W-9:0]};  // /S/ then D1..D7
        dec_ctrl  = 8'h80;
        dec_class = BLK_S;
      end
      else if (block_type == `BT_ORDER)
      begin
        // lanes 4..7 carry idle, only code 00 is legal there
        fill_ok  = (payload[27:0] == '0);
        dec_data = {(o_code == 4'hF) ? `XGMII_SIG : `XGMII_SEQ,
                    payload[`PCS_DATA_W-9:32],
                    {4{`XGMII_IDLE}}};
        dec_ctrl = 8'h8F;
        if (fill_ok && ((o_code == 4'h0) || (o_code == 4'hF)))
          dec_class = BLK_C;
      end
      else if (term_hit)
      begin
        for (int j = 0; j < NUM_LANES; j++)
        begin
          if (j == term_k)
            dec_data[`PCS_DATA_W-1-8*j -: 8] = `XGMII_TERM;
          else if (j > term_k)
          begin
            dec_data[`PCS_DATA_W-1-8*j -: 8] = char_byte[j];  // fill after /T/
            fill_ok = fill_ok & char_ok[j];
          end
          else
            dec_data[`PCS_DATA_W-1-8*j -: 8] = term_bytes[`PCS_DATA_W-1-8*j -: 8];
        end
        dec_ctrl = {`PCS_CTRL_W{1'b1}} >> term_k;  // lane k and up are control
        if (fill_ok)
          dec_class = BLK_T;
      end
    end
  end

  assign o_valid       = rx_valid;
  assign o_rx_data     = dec_data;
  assign o_rx_ctrl     = dec_ctrl;
  assign o_block_class = dec_class;

endmodule

//--- rtl/rx_state_machine.sv
`timescale 1ns/10ps
`include "pcs_rx_defs.svh"

module rx_state_machine
  import pcs_rx_pkg::*;
(
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  logic                   i_valid,
  input  logic [`PCS_DATA_W-1:0] i_rx_data,
  input  logic [`PCS_CTRL_W-1:0] i_rx_ctrl,
  input  block_class_t           i_block_class,
  output logic                   o_valid,
  output logic [`PCS_DATA_W-1:0] o_rx_data,
  output logic [`PCS_CTRL_W-1:0] o_rx_ctrl
);

  // local fault: sequence ordered set with 01 in lane 3
  localparam logic [`PCS_DATA_W-1:0] LF_DATA  = {`XGMII_SEQ, 8'h00, 8'h00, 8'h01, 32'h0};
  localparam logic [`PCS_CTRL_W-1:0] LF_CTRL  = 8'h80;
  localparam logic [`PCS_DATA_W-1:0] ERR_DATA = {`PCS_CTRL_W{`XGMII_ERROR}};
  localparam logic [`PCS_CTRL_W-1:0] ERR_CTRL = '1;

  rx_state_t state;
  rx_state_t next_state;
  logic      pass;     // decoded word goes out
  logic      send_lf;  // local fault goes out

  ////////////////////////////////////////
  // block order check
  ////////////////////////////////////////
  always_comb
  begin
    next_state = state;
    pass       = 1'b0;
    send_lf    = 1'b0;
    case (state)
      RX_INIT:
      begin
        send_lf = 1'b1;  // link not up yet, even C or S is masked
        if (i_block_class == BLK_C)
          next_state = RX_C;
        else if (i_block_class == BLK_S)
          next_state = RX_D;
        else
        begin
          next_state = RX_E;
          send_lf    = 1'b0;
        end
      end
      RX_C:
      begin
        pass = (i_block_class == BLK_C) || (i_block_class == BLK_S);
        if (i_block_class == BLK_S)
          next_state = RX_D;
        else if (i_block_class != BLK_C)
          next_state = RX_E;  // D or T outside a frame
      end
      RX_D:
      begin
        pass = (i_block_class == BLK_D) || (i_block_class == BLK_T);
        if (i_block_class == BLK_T)
          next_state = RX_C;  // frame closed
        else if (i_block_class != BLK_D)
          next_state = RX_E;
      end
      default:  // RX_E, S alone does not recover
      begin
        pass = 1'b1;
        if ((i_block_class == BLK_C) || (i_block_class == BLK_T))
          next_state = RX_C;
        else if (i_block_class == BLK_D)
          next_state = RX_D;
        else
          pass = 1'b0;
      end
    endcase
  end

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
    begin
      state   <= RX_INIT;
      o_valid <= 1'b0;
    end
    else
    begin
      o_valid <= i_valid;
      if (i_valid)
        state <= next_state;
    end
  end

  // output word, decoded / local fault / error block
  always_ff @(posedge i_clock)
  begin
    if (i_valid)
    begin
      if (pass)
      begin
        o_rx_data <= i_rx_data;
        o_rx_ctrl <= i_rx_ctrl;
      end
      else if (send_lf)
      begin
        o_rx_data <= LF_DATA;
        o_rx_ctrl <= LF_CTRL;
      end
      else
      begin
        o_rx_data <= ERR_DATA;
        o_rx_ctrl <= ERR_CTRL;
      end
    end
  end

endmodule

//--- rtl/pcs_rx_top.sv
`timescale 1ns/10ps
`include "pcs_rx_defs.svh"

module pcs_rx_top
  import pcs_rx_pkg::*;
(
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_valid,
  input  logic [`PCS_CODED_W-1:0] i_rx_coded,
  output logic                    o_valid,
  output logic [`PCS_DATA_W-1:0]  o_rx_data,
  output logic [`PCS_CTRL_W-1:0]  o_rx_ctrl
);

  ////////////////////////////////////////
  // stage wires
  ////////////////////////////////////////
  logic                    scr_valid;   // descrambler -> decoder
  logic [`PCS_CODED_W-1:0] scr_block;
  logic                    dec_valid;   // decoder -> fsm
  logic [`PCS_DATA_W-1:0]  dec_data;
  logic [`PCS_CTRL_W-1:0]  dec_ctrl;
  block_class_t            dec_class;

  rx_descrambler u_descrambler
  (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_block (i_rx_coded),
    .o_valid (scr_valid),
    .o_block (scr_block)
  );

  decoder_comparator u_decoder
  (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_valid       (scr_valid),
    .i_rx_coded    (scr_block),
    .o_valid       (dec_valid),
    .o_rx_data     (dec_data),
    .o_rx_ctrl     (dec_ctrl),
    .o_block_class (dec_class)
  );

  rx_state_machine u_rx_fsm
  (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_valid       (dec_valid),
    .i_rx_data     (dec_data),
    .i_rx_ctrl     (dec_ctrl),
    .i_block_class (dec_class),
    .o_valid       (o_valid),
    .o_rx_data     (o_rx_data),
    .o_rx_ctrl     (o_rx_ctrl)
  );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
(
  output logic o_clock,
  output logic o_reset
);

  localparam real HALF_PERIOD  = 2.0;  // 4 ns clock
  localparam int  RESET_CYCLES = 3;

  initial
  begin
    o_clock = 1'b0;
    forever #HALF_PERIOD o_clock = ~o_clock;
  end

  // reset drops on a falling edge, like all other stimulus
  initial
  begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clock);
    @(negedge o_clock);
    o_reset = 1'b0;
  end

endmodule

//--- testbench/pcs_rx_checker.sv
`timescale 1ns/10ps
`include "pcs_rx_defs.svh"

module pcs_rx_checker
(
  input logic i_clock,
  input logic i_reset,
  input logic i_valid,      // top level input strobe
  input logic i_out_valid   // top level output strobe
);

  ////////////////////////////////////////
  // strobe timing through the pipeline
  ////////////////////////////////////////

  // one output per input, fixed latency, nothing extra
  assert property (@(posedge i_clock) disable iff (i_reset)
    i_out_valid == $past(i_valid, `PCS_RX_LATENCY))
  else
    $error("o_valid does not follow i_valid by %0d cycles", `PCS_RX_LATENCY);

  // every stage clears its strobe in reset
  assert property (@(posedge i_clock) i_reset |=> !i_out_valid)
  else
    $error("o_valid high after a reset cycle");

endmodule

// checker rides along with every pcs_rx_top instance
bind pcs_rx_top pcs_rx_checker u_checker
(
  .i_clock     (i_clock),
  .i_reset     (i_reset),
  .i_valid     (i_valid),
  .i_out_valid (o_valid)
);

//--- testbench/pcs_rx_tb.sv
`timescale 1ns/10ps
`include "pcs_rx_defs.svh"

module pcs_rx_tb
  import pcs_rx_pkg::*;
();

  localparam int NUM_BLOCKS = 2000;
  localparam int MAX_CYCLES = (NUM_BLOCKS + 16) * 4 + 100;  // 4 cycles a block, well above the mean

  // block kinds the generator can build
  localparam int K_IDLE = 0, K_START = 1, K_DATA = 2, K_TERM = 3, K_ORDER = 4;
  localparam int K_BAD_OS = 5, K_BAD_HDR = 6, K_BAD_TYPE = 7, K_BAD_CHAR = 8;
  localparam int ACT_PASS = 0, ACT_LF = 1, ACT_ERR = 2;

  localparam logic [71:0] LF_WORD  = {8'h80, 64'h9C00_0001_0000_0000};
  localparam logic [71:0] ERR_WORD = {8'hFF, {8{`XGMII_ERROR}}};
  localparam logic [7:0]  TERM_TYPE [8] = '{`BT_T0, `BT_T1, `BT_T2, `BT_T3,
                                            `BT_T4, `BT_T5, `BT_T6, `BT_T7};

  logic        clock;
  logic        gen_reset;
  logic        tb_reset = 1'b0;  // second reset, mid run
  logic        dut_reset;
  logic        rx_valid = 1'b0;
  logic [65:0] rx_coded = '0;
  logic        o_valid;
  logic [63:0] o_data;
  logic [7:0]  o_ctrl;

  logic [31:0] lfsr = 32'hcf41bf8c;
  logic [57:0] scr = '0;           // scrambler model state
  rx_state_t   model_state = RX_INIT;
  logic        in_frame = 1'b0;    // steers the generator only
  logic [71:0] exp_q [$];          // {ctrl, data} per block in flight
  logic [2:0]  vpipe = '0;         // strobes driven over the last 3 cycles
  int          errors = 0;
  int          checked = 0;
  int          cycles = 0;

  assign dut_reset = gen_reset | tb_reset;

  tb_clock_gen u_clock_gen (.o_clock(clock), .o_reset(gen_reset));

  pcs_rx_top dut0
  (
    .i_clock    (clock),
    .i_reset    (dut_reset),
    .i_valid    (rx_valid),
    .i_rx_coded (rx_coded),
    .o_valid    (o_valid),
    .o_rx_data  (o_data),
    .o_rx_ctrl  (o_ctrl)
  );

  ////////////////////////////////////////
  // random source and line model
  ////////////////////////////////////////
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);  // galois step
    end
    return r;
  endfunction

  // x^58 + x^39 + 1, the line bit feeds back
  function automatic logic [63:0] scramble(input logic [63:0] plain);
    logic [63:0] line;
    for (int i = 0; i < 64; i++)
    begin
      line[i] = plain[i] ^ scr[38] ^ scr[57];
      scr     = {scr[56:0], line[i]};
    end
    return line;
  endfunction

  ////////////////////////////////////////
  // block builder with expected word
  ////////////////////////////////////////
  task automatic make_block(input int kind, output logic [65:0] blk,
                            output logic [71:0] word, output block_class_t cls);
    logic [63:0] pay;
    logic [63:0] exp_d;
    logic [7:0]  exp_c;
    logic [31:0] r;
    logic [6:0]  ch;
    int          k;
    pay   = '0;
    exp_d = '0;
    exp_c = '0;
    cls   = BLK_E;
    blk   = '0;
    case (kind)
      K_DATA, K_BAD_HDR:
      begin
        for (int j = 0; j < 8; j++)
        begin
          r = rand_bits(8);
          pay[63-8*j -: 8] = r[7:0];
        end
        exp_d = pay;     // ctrl stays 00
        cls   = BLK_D;
        blk   = {2'b01, pay};
        if (kind == K_BAD_HDR)
        begin
          r   = rand_bits(1);
          blk = {r[0] ? 2'b11 : 2'b00, pay};  // neither 01 nor 10
          cls = BLK_E;
        end
      end
      K_IDLE, K_BAD_CHAR:
      begin
        pay[63:56] = `BT_CTRL;
        for (int j = 0; j < 8; j++)
        begin
          ch = (rand_bits(2) == 3) ? `PCS_ERROR : `PCS_IDLE;  // mostly idle
          pay[55-7*j -: 7] = ch;
          exp_d[63-8*j -: 8] = (ch == `PCS_ERROR) ? `XGMII_ERROR : `XGMII_IDLE;
        end
        exp_c = 8'hFF;
        cls   = BLK_C;
        if (kind == K_BAD_CHAR)
        begin
          k = rand_bits(3);
          pay[55-7*k -: 7] = 7'h2D;  // not a legal code
          cls = BLK_E;
        end
        blk = {2'b10, pay};
      end
      K_START:
      begin
        pay[63:56] = `BT_START;
        for (int j = 1; j < 8; j++)
        begin
          r = rand_bits(8);
          pay[63-8*j -: 8] = r[7:0];
        end
        exp_d = {`XGMII_START, pay[55:0]};
        exp_c = 8'h80;
        cls   = BLK_S;
        blk   = {2'b10, pay};
      end
      K_ORDER, K_BAD_OS:
      begin
        pay[63:56] = `BT_ORDER;
        r = rand_bits(24);
        pay[55:32] = r[23:0];
        r = rand_bits(1);
        pay[31:28] = r[0] ? 4'hF : 4'h0;
        exp_d = {r[0] ? `XGMII_SIG : `XGMII_SEQ, pay[55:32], {4{`XGMII_IDLE}}};
        exp_c = 8'h8F;
        cls   = BLK_C;
        if (kind == K_BAD_OS)
        begin
          r = rand_bits(27);
          pay[27:0] = {r[26:0], 1'b1};  // filler never zero
          cls = BLK_E;
        end
        blk = {2'b10, pay};
      end
      K_TERM:
      begin
        k = rand_bits(3);
        r = rand_bits(24);
        pay[55:32] = r[23:0];  // data and pad bits random
        pay[31:0]  = rand_bits(32);
        pay[63:56] = TERM_TYPE[k];
        for (int j = 0; j < 8; j++)
        begin
          if (j < k)
            exp_d[63-8*j -: 8] = pay[55-8*j -: 8];  // D(j+1)
          else if (j == k)
            exp_d[63-8*j -: 8] = `XGMII_TERM;
          else
          begin
            ch = (rand_bits(1) == 1) ? `PCS_ERROR : `PCS_IDLE;
            pay[55-7*j -: 7] = ch;
            exp_d[63-8*j -: 8] = (ch == `PCS_ERROR) ? `XGMII_ERROR : `XGMII_IDLE;
          end
          if (j >= k)
            exp_c[7-j] = 1'b1;
        end
        cls = BLK_T;
        blk = {2'b10, pay};
      end
      default:  // K_BAD_TYPE
      begin
        r = rand_bits(4);
        pay[63:56] = {4'h3, r[3:0]};  // no block type lives in 3x
        r = rand_bits(24);
        pay[55:32] = r[23:0];
        pay[31:0]  = rand_bits(32);
        blk = {2'b10, pay};
      end
    endcase
    word = {exp_c, exp_d};
  endtask

  // block order table, returns what the link sends for this class
  function automatic int order_model(input block_class_t cls);
    int act;
    act = ACT_ERR;
    case (model_state)
      RX_INIT:
      begin
        if ((cls == BLK_C) || (cls == BLK_S))
          act = ACT_LF;  // link comes up on this block
        model_state = (cls == BLK_C) ? RX_C : (cls == BLK_S) ? RX_D : RX_E;
      end
      RX_C:
      begin
        if ((cls == BLK_C) || (cls == BLK_S))
          act = ACT_PASS;
        model_state = (cls == BLK_C) ? RX_C : (cls == BLK_S) ? RX_D : RX_E;
      end
      RX_D:
      begin
        if ((cls == BLK_D) || (cls == BLK_T))
          act = ACT_PASS;
        model_state = (cls == BLK_D) ? RX_D : (cls == BLK_T) ? RX_C : RX_E;
      end
      default:
      begin
        if ((cls == BLK_C) || (cls == BLK_T))
        begin
          act = ACT_PASS;
          model_state = RX_C;
        end
        else if (cls == BLK_D)
        begin
          act = ACT_PASS;
          model_state = RX_D;
        end
      end
    endcase
    return act;
  endfunction

  ////////////////////////////////////////
  // per cycle check and drive
  ////////////////////////////////////////
  task automatic step_cycle(input logic v, input logic [65:0] blk);
    logic [71:0] exp;
    @(negedge clock);
    if (o_valid !== vpipe[2])
    begin
      errors++;
      $display("FAILED at %0t: o_valid %b, expected %b", $time, o_valid, vpipe[2]);
    end
    if (o_valid === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("output strobe at %0t with no block in flight", $time);
      end
      else
      begin
        exp = exp_q.pop_front();
        checked++;
        if ({o_ctrl, o_data} !== exp)
        begin
          errors++;
          $display("FAILED at %0t: got ctrl %h data %h, expected ctrl %h data %h",
                   $time, o_ctrl, o_data, exp[71:64], exp[63:0]);
        end
      end
    end
    rx_valid = v;
    rx_coded = blk;
    vpipe    = {vpipe[1:0], v};
  endtask

  task automatic send_block(input int kind);
    logic [65:0]  blk;
    logic [71:0]  word;
    block_class_t cls;
    int           act;
    int           gap;
    make_block(kind, blk, word, cls);
    gap = (rand_bits(3) == 0) ? rand_bits(2) + 1 : 0;  // idle strobes before it
    repeat (gap) step_cycle(1'b0, rx_coded);
    act = order_model(cls);
    if (act == ACT_LF)
      word = LF_WORD;
    else if (act == ACT_ERR)
      word = ERR_WORD;
    exp_q.push_back(word);
    step_cycle(1'b1, {blk[65:64], scramble(blk[63:0])});
  endtask

  // mostly legal frames, one block in 16 is special
  function automatic int pick_kind();
    int r;
    int kind;
    r = rand_bits(4);
    if (r == 0)
    begin
      case (rand_bits(3))
        0: kind = K_ORDER;
        1: kind = K_BAD_OS;
        2: kind = K_BAD_HDR;
        3: kind = K_BAD_TYPE;
        4: kind = K_BAD_CHAR;
        5: kind = K_DATA;   // out of order when outside a frame
        6: kind = K_START;  // start inside data
        default: kind = K_TERM;
      endcase
    end
    else if (!in_frame)
      kind = (r < 12) ? K_IDLE : K_START;
    else
      kind = (r < 11) ? K_DATA : K_TERM;
    if (kind == K_START)
      in_frame = 1'b1;
    else if ((kind == K_TERM) || (kind == K_IDLE) || (kind == K_ORDER))
      in_frame = 1'b0;
    return kind;
  endfunction

  task automatic drain();
    while ((exp_q.size() != 0) || (vpipe != 3'b000))
      step_cycle(1'b0, rx_coded);
  endtask

  // reset hits with blocks in flight, the dut drops all of them
  task automatic apply_reset();
    tb_reset = 1'b1;
    exp_q.delete();
    vpipe    = '0;
    repeat (4) step_cycle(1'b0, rx_coded);  // outlasts the latency of the last strobe
    tb_reset    = 1'b0;
    scr         = '0;       // dut clears its descrambler too
    model_state = RX_INIT;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial
  begin
    @(negedge clock);
    while (gen_reset)
      @(negedge clock);
    send_block(K_DATA);   // data first, error block
    send_block(K_IDLE);   // recovers from error
    drain();
    send_block(K_START);  // reset below drops what is still in flight
    send_block(K_DATA);
    apply_reset();
    send_block(K_IDLE);   // first control, local fault
    repeat (NUM_BLOCKS) send_block(pick_kind());
    drain();
    $display("blocks checked %0d, errors %0d", checked, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  always @(posedge clock)
  begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES)
    begin
      $display("timeout after %0d cycles, %0d outputs never arrived", cycles, exp_q.size());
      $display("Test failed");
      $finish;
    end
  end

endmodule

//--- project.f
+incdir+rtl
rtl/pcs_rx_pkg.sv
rtl/rx_descrambler.sv
rtl/decoder_comparator.sv
rtl/rx_state_machine.sv
rtl/pcs_rx_top.sv
testbench/tb_clock_gen.sv
testbench/pcs_rx_checker.sv
testbench/pcs_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the pcs receive testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module pcs_rx_tb \
  -Mdir "$build_dir" -o pcs_rx_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# keep running past assertion errors so the testbench can report them
"./$build_dir/pcs_rx_sim" +verilator+error+limit+1000 > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$log_file"; then
  exit 1
fi
exit 0
